//--- rtl/aimbot_pkg.sv
package aimbot_pkg;

    typedef logic [15:0] pixel_t;   // rgb565, red in [15:11]
    typedef logic [15:0] addr_t;    // word address into the frame buffer
    typedef logic [1:0]  resp_t;

    localparam resp_t resp_okay   = 2'b00;
    localparam resp_t resp_slverr = 2'b10;

    // ******************************
    // axi4-lite channels
    // ******************************

    typedef struct packed {
        addr_t addr;
        logic  valid;
    } axil_aw_t;

    typedef struct packed {
        pixel_t     data;
        logic [1:0] strb;   // [1] high byte, [0] low byte
        logic       valid;
    } axil_w_t;

    typedef struct packed {
        resp_t resp;
        logic  valid;
    } axil_b_t;

    typedef struct packed {
        addr_t addr;
        logic  valid;
    } axil_ar_t;

    typedef struct packed {
        pixel_t data;
        resp_t  resp;
        logic   valid;
    } axil_r_t;

    typedef struct packed {
        axil_aw_t aw;
        axil_w_t  w;
        axil_ar_t ar;
        logic     bready;
        logic     rready;
    } axil_req_t;   // master to slave

    typedef struct packed {
        logic    awready;
        logic    wready;
        axil_b_t b;
        logic    arready;
        axil_r_t r;
    } axil_rsp_t;   // slave to master

endpackage : aimbot_pkg

//--- rtl/aimbot_top.sv
`timescale 1ns/1ps

module aimbot_top import aimbot_pkg::*; #(
    parameter int frame_pixels = 32
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cam1_vsync,
    input  logic       cam1_href,
    input  logic [7:0] cam1_data,
    input  logic       cam2_vsync,
    input  logic       cam2_href,
    input  logic [7:0] cam2_data,
    input  logic       disp_start,
    output logic       disp_busy,
    output logic       hdmi_de,
    output logic [7:0] hdmi_r,
    output logic [7:0] hdmi_g,
    output logic [7:0] hdmi_b,
    output logic       overflow1,
    output logic       overflow2
);

    localparam int n_masters = 3;

    axil_req_t [n_masters-1:0] m_req;   // 0 cam1, 1 cam2, 2 display
    axil_rsp_t [n_masters-1:0] m_rsp;
    axil_req_t                 ram_req;
    axil_rsp_t                 ram_rsp;

    // ******************************
    // camera writers
    // ******************************

    ov5640_reader #(.frame_pixels(frame_pixels), .cam_base(0)) u_cam1_reader (
        .clk     (clk       ),
        .rst_n   (rst_n     ),
        .vsync   (cam1_vsync),
        .href    (cam1_href ),
        .data    (cam1_data ),
        .mem_req (m_req[0]  ),
        .mem_rsp (m_rsp[0]  ),
        .overflow(overflow1 )
    );

    ov5640_reader #(.frame_pixels(frame_pixels), .cam_base(frame_pixels)) u_cam2_reader (
        .clk     (clk       ),
        .rst_n   (rst_n     ),
        .vsync   (cam2_vsync),
        .href    (cam2_href ),
        .data    (cam2_data ),
        .mem_req (m_req[1]  ),
        .mem_rsp (m_rsp[1]  ),
        .overflow(overflow2 )
    );

    display_reader #(.frame_pixels(frame_pixels)) u_display_reader (
        .clk       (clk       ),
        .rst_n     (rst_n     ),
        .disp_start(disp_start),
        .mem_req   (m_req[2]  ),
        .mem_rsp   (m_rsp[2]  ),
        .busy      (disp_busy ),
        .hdmi_de   (hdmi_de   ),
        .hdmi_r    (hdmi_r    ),
        .hdmi_g    (hdmi_g    ),
        .hdmi_b    (hdmi_b    )
    );

    // ******************************
    // shared frame memory
    // ******************************

    mem_arbiter #(.n_masters(n_masters)) u_mem_arbiter (
        .clk  (clk    ),
        .rst_n(rst_n  ),
        .m_req(m_req  ),
        .m_rsp(m_rsp  ),
        .s_req(ram_req),
        .s_rsp(ram_rsp)
    );

    frame_ram #(.frame_pixels(frame_pixels)) u_frame_ram (
        .clk  (clk    ),
        .rst_n(rst_n  ),
        .s_req(ram_req),
        .s_rsp(ram_rsp)
    );

endmodule : aimbot_top

//--- rtl/display_reader.sv
`timescale 1ns/1ps

module display_reader import aimbot_pkg::*; #(
    parameter int frame_pixels = 32
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       disp_start,
    output axil_req_t  mem_req,
    input  axil_rsp_t  mem_rsp,
    output logic       busy,
    output logic       hdmi_de,
    output logic [7:0] hdmi_r,
    output logic [7:0] hdmi_g,
    output logic [7:0] hdmi_b
);

    localparam int depth = 2 * frame_pixels;

    typedef enum logic [1:0] {st_idle, st_addr, st_data} rd_state_t;

    rd_state_t state;
    addr_t     addr_q;
    pixel_t    pix_q;
    logic      de_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= st_idle;
            addr_q <= '0;
            de_q   <= 1'b0;
        end else begin
            de_q <= 1'b0;
            case (state)
                st_idle: if (disp_start) begin
                    addr_q <= '0;
                    state  <= st_addr;
                end
                st_addr: if (mem_rsp.arready)
                    state <= st_data;
                st_data: if (mem_rsp.r.valid) begin
                    de_q <= 1'b1;
                    if (addr_q == addr_t'(depth - 1)) begin
                        state <= st_idle;   // frame done
                    end else begin
                        addr_q <= addr_q + 1'b1;
                        state  <= st_addr;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_data && mem_rsp.r.valid)
            pix_q <= mem_rsp.r.data;
    end

    always_comb begin
        mem_req          = '0;
        mem_req.ar.valid = (state == st_addr);
        mem_req.ar.addr  = addr_q;
        mem_req.rready   = (state == st_data);
    end

    assign busy    = (state != st_idle);
    assign hdmi_de = de_q;
    assign hdmi_r  = {pix_q[15:11], 3'b000};  // zero pad the low bits
    assign hdmi_g  = {pix_q[10:5], 2'b00};
    assign hdmi_b  = {pix_q[4:0], 3'b000};

    a_de_single : assert property (@(posedge clk) disable iff (!rst_n)
        hdmi_de |=> !hdmi_de);

    // the last pixel leaves on the cycle busy drops
    a_end_of_frame : assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy) |-> hdmi_de);

endmodule : display_reader

//--- rtl/frame_ram.sv
`timescale 1ns/1ps

module frame_ram import aimbot_pkg::*; #(
    parameter int frame_pixels = 32
) (
    input  logic      clk,
    input  logic      rst_n,
    input  axil_req_t s_req,
    output axil_rsp_t s_rsp
);

    localparam int depth = 2 * frame_pixels;
    localparam int idx_w = $clog2(depth);

    pixel_t           mem [depth];
    logic             b_valid;
    resp_t            b_resp;
    logic             r_valid;
    resp_t            r_resp;
    pixel_t           r_data;
    logic             idle;
    logic             wr_fire;
    logic             rd_fire;
    logic             wr_in_range;
    logic             rd_in_range;
    logic [idx_w-1:0] wr_idx;
    logic [idx_w-1:0] rd_idx;

    assign idle        = !b_valid && !r_valid;  // one transaction at a time
    assign wr_fire     = idle && s_req.aw.valid && s_req.w.valid;
    assign rd_fire     = idle && s_req.ar.valid && !wr_fire;
    assign wr_in_range = s_req.aw.addr < addr_t'(depth);
    assign rd_in_range = s_req.ar.addr < addr_t'(depth);
    assign wr_idx      = s_req.aw.addr[idx_w-1:0];
    assign rd_idx      = s_req.ar.addr[idx_w-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            b_valid <= 1'b0;
            b_resp  <= resp_okay;
            r_valid <= 1'b0;
            r_resp  <= resp_okay;
        end else begin
            if (wr_fire) begin
                b_valid <= 1'b1;
                b_resp  <= wr_in_range ? resp_okay : resp_slverr;
            end else if (b_valid && s_req.bready) begin
                b_valid <= 1'b0;
            end
            if (rd_fire) begin
                r_valid <= 1'b1;
                r_resp  <= rd_in_range ? resp_okay : resp_slverr;
            end else if (r_valid && s_req.rready) begin
                r_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire && wr_in_range) begin
            if (s_req.w.strb[1])
                mem[wr_idx][15:8] <= s_req.w.data[15:8];
            if (s_req.w.strb[0])
                mem[wr_idx][7:0] <= s_req.w.data[7:0];
        end
        if (rd_fire)
            r_data <= rd_in_range ? mem[rd_idx] : '0;
    end

    always_comb begin
        s_rsp         = '0;
        s_rsp.awready = wr_fire;
        s_rsp.wready  = wr_fire;
        s_rsp.arready = rd_fire;
        s_rsp.b.valid = b_valid;
        s_rsp.b.resp  = b_resp;
        s_rsp.r.valid = r_valid;
        s_rsp.r.resp  = r_resp;
        s_rsp.r.data  = r_data;
    end

    a_one_rsp : assert property (@(posedge clk) disable iff (!rst_n)
        !(s_rsp.b.valid && s_rsp.r.valid));

endmodule : frame_ram

//--- rtl/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter import aimbot_pkg::*; #(
    parameter int n_masters = 3
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  axil_req_t [n_masters-1:0] m_req,
    output axil_rsp_t [n_masters-1:0] m_rsp,
    output axil_req_t                 s_req,
    input  axil_rsp_t                 s_rsp
);

    localparam int idx_w = (n_masters > 1) ? $clog2(n_masters) : 1;

    logic [idx_w-1:0] last;     // last granted port
    logic [idx_w-1:0] owner;
    logic             locked;
    logic [idx_w-1:0] pick;
    logic             pick_vld;
    logic [idx_w-1:0] grant;
    logic             grant_vld;
    logic             resp_done;

    // ******************************
    // round robin pick
    // ******************************

    always_comb begin
        int cand;
        pick     = last;
        pick_vld = 1'b0;
        // walk backwards so the port right after last wins
        for (int i = n_masters; i >= 1; i--) begin
            cand = (int'(last) + i) % n_masters;
            if (m_req[cand].aw.valid || m_req[cand].ar.valid) begin
                pick     = idx_w'(cand);
                pick_vld = 1'b1;
            end
        end
    end

    assign grant     = locked ? owner : pick;
    assign grant_vld = locked || pick_vld;
    assign resp_done = (s_rsp.b.valid && s_req.bready) || (s_rsp.r.valid && s_req.rready);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            locked <= 1'b0;
            owner  <= '0;
            last   <= idx_w'(n_masters - 1);    // port 0 goes first
        end else begin
            if (!locked && pick_vld) begin
                locked <= 1'b1;
                owner  <= pick;
                last   <= pick;
            end else if (locked && resp_done) begin
                locked <= 1'b0;
            end
        end
    end

    // ******************************
    // channel routing
    // ******************************

    always_comb begin
        s_req = '0;
        if (grant_vld)
            s_req = m_req[grant];
        for (int i = 0; i < n_masters; i++) begin
            if (grant_vld && grant == idx_w'(i))
                m_rsp[i] = s_rsp;
            else
                m_rsp[i] = '0;  // all readies low
        end
    end

    // a slave response only shows up for the port that issued the request
    a_grant_stable : assert property (@(posedge clk) disable iff (!rst_n)
        (s_rsp.b.valid || s_rsp.r.valid) |-> locked && $stable(grant));

endmodule : mem_arbiter

//--- rtl/ov5640_reader.sv
`timescale 1ns/1ps

module ov5640_reader import aimbot_pkg::*; #(
    parameter int frame_pixels = 32,
    parameter int cam_base     = 0
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       vsync,
    input  logic       href,
    input  logic [7:0] data,
    output axil_req_t  mem_req,
    input  axil_rsp_t  mem_rsp,
    output logic       overflow
);

    typedef enum logic {wr_send, wr_resp} wr_state_t;

    logic       phase;      // high once the first byte of a pair is in
    logic [7:0] hi_byte;
    addr_t      pix_idx;
    logic       pix_vld;
    pixel_t     pix_q;
    addr_t      pix_addr;
    pixel_t     fifo_pix  [4];
    addr_t      fifo_addr [4];
    logic [1:0] wr_ptr;
    logic [1:0] rd_ptr;
    logic [2:0] count;
    logic       full;
    logic       push;
    logic       pop;
    wr_state_t  state;

    // ******************************
    // byte pairing
    // ******************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase   <= 1'b0;
            pix_idx <= '0;
            pix_vld <= 1'b0;
        end else begin
            pix_vld <= 1'b0;
            if (vsync) begin
                phase   <= 1'b0;
                pix_idx <= '0;
            end else if (href) begin
                phase <= !phase;
                if (phase) begin
                    pix_vld <= 1'b1;
                    pix_idx <= (pix_idx == addr_t'(frame_pixels - 1)) ? '0 : pix_idx + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (href && !phase)
            hi_byte <= data;
        if (href && phase) begin
            pix_q    <= {hi_byte, data};
            pix_addr <= addr_t'(cam_base) + pix_idx;  // address fixed when the pixel completes
        end
    end

    // ******************************
    // pixel fifo
    // ******************************

    assign full = (count == 3'd4);
    assign push = pix_vld && !full;
    assign pop  = (state == wr_resp) && mem_rsp.b.valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + 3'(push) - 3'(pop);
            if (pix_vld && full)
                overflow <= 1'b1;   // sticky
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_pix[wr_ptr]  <= pix_q;
            fifo_addr[wr_ptr] <= pix_addr;
        end
    end

    // ******************************
    // write channel
    // ******************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= wr_send;
        end else begin
            case (state)
                wr_send: if (mem_req.aw.valid && mem_rsp.awready && mem_rsp.wready)
                    state <= wr_resp;
                wr_resp: if (mem_rsp.b.valid)
                    state <= wr_send;
                default: state <= wr_send;
            endcase
        end
    end

    always_comb begin
        mem_req          = '0;
        mem_req.aw.valid = (state == wr_send) && (count != 3'd0);
        mem_req.aw.addr  = fifo_addr[rd_ptr];
        mem_req.w.valid  = mem_req.aw.valid;
        mem_req.w.data   = fifo_pix[rd_ptr];
        mem_req.w.strb   = 2'b11;
        mem_req.bready   = (state == wr_resp);
    end

    // aw and w are taken on the same cycle
    a_aw_w_paired : assert property (@(posedge clk) disable iff (!rst_n)
        mem_req.aw.valid |-> (mem_rsp.awready == mem_rsp.wready));

    // a pending write may not be withdrawn before the arbiter passes it on
    a_aw_hold : assert property (@(posedge clk) disable iff (!rst_n)
        mem_req.aw.valid && !mem_rsp.awready |=> mem_req.aw.valid);

endmodule : ov5640_reader

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal --top-module aimbot_tb \
        -f verilog.f -o aimbot_sim \
    && ./obj_dir/aimbot_sim \
    || { echo "simulation did not pass"; exit 1; }

//--- verification/aimbot_stimulus.txt
// camera bytes, high byte first: cam1 pixels 0-31 (rows 1-2), cam2 pixels 32-63 (rows 3-4)
// then the expected rgb888 display word for frame addresses 0-63, eight per row
00 ff 04 fb 08 f7 0c f3 10 ef 14 eb 18 e7 1c e3 20 df 24 db 28 d7 2c d3 30 cf 34 cb 38 c7 3c c3
40 bf 44 bb 48 b7 4c b3 50 af 54 ab 58 a7 5c a3 60 9f 64 9b 68 97 6c 93 70 8f 74 8b 78 87 7c 83
80 7f 84 7b 88 77 8c 73 90 6f 94 6b 98 67 9c 63 a0 5f a4 5b a8 57 ac 53 b0 4f b4 4b b8 47 bc 43
c0 3f c4 3b c8 37 cc 33 d0 2f d4 2b d8 27 dc 23 e0 1f e4 1b e8 17 ec 13 f0 0f f4 0b f8 07 fc 03
001cf8 009cd8 081cb8 089c98 101c78 109c58 181c38 189c18
2018f8 2098d8 2818b8 289898 301878 309858 381838 389818
4014f8 4094d8 4814b8 489498 501478 509458 581438 589418
6010f8 6090d8 6810b8 689098 701078 709058 781038 789018
800cf8 808cd8 880cb8 888c98 900c78 908c58 980c38 988c18
a008f8 a088d8 a808b8 a88898 b00878 b08858 b80838 b88818
c004f8 c084d8 c804b8 c88498 d00478 d08458 d80438 d88418
e000f8 e080d8 e800b8 e88098 f00078 f08058 f80038 f88018

//--- verification/aimbot_tb.sv
`timescale 1ns/1ps

module aimbot_tb;

    localparam int frame_pixels = 32;
    localparam int n_pixels     = 2 * frame_pixels;
    localparam int stim_bytes   = 64 + 128 + 85 + 128;  // camera bytes driven over all tests
    localparam int cycle_limit  = 20 * stim_bytes + 500;

    logic        clk;
    logic        rst_n;
    logic        cam1_vsync;
    logic        cam1_href;
    logic [7:0]  cam1_data;
    logic        cam2_vsync;
    logic        cam2_href;
    logic [7:0]  cam2_data;
    logic        disp_start;
    logic        disp_busy;
    logic        hdmi_de;
    logic [7:0]  hdmi_r;
    logic [7:0]  hdmi_g;
    logic [7:0]  hdmi_b;
    logic        overflow1;
    logic        overflow2;

    logic [23:0] stim [0:191];     // 128 camera bytes, then 64 expected words
    logic [23:0] seen [$];         // display words in arrival order
    logic [15:0] lfsr_state = 16'd54;
    int          cycles     = 0;

    aimbot_top #(.frame_pixels(frame_pixels)) uut (
        .clk       (clk       ),
        .rst_n     (rst_n     ),
        .cam1_vsync(cam1_vsync),
        .cam1_href (cam1_href ),
        .cam1_data (cam1_data ),
        .cam2_vsync(cam2_vsync),
        .cam2_href (cam2_href ),
        .cam2_data (cam2_data ),
        .disp_start(disp_start),
        .disp_busy (disp_busy ),
        .hdmi_de   (hdmi_de   ),
        .hdmi_r    (hdmi_r    ),
        .hdmi_g    (hdmi_g    ),
        .hdmi_b    (hdmi_b    ),
        .overflow1 (overflow1 ),
        .overflow2 (overflow2 )
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("run timed out after %0d cycles", cycles);
            $display("tests failed");
            $fatal(1, "timeout");
        end
    end

    always @(negedge clk) begin
        if (rst_n && hdmi_de)
            seen.push_back({hdmi_r, hdmi_g, hdmi_b});
    end

    // ******************************
    // helpers
    // ******************************

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    function automatic bit href_slot();
        bit b0;
        bit b1;
        b0 = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
        b1 = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
        return !(b0 || b1);     // a byte on about a quarter of the cycles
    endfunction

    function automatic logic [15:0] cam_pixel(input int k, input bit inv);
        logic [15:0] p;
        p = {stim[2*k][7:0], stim[2*k+1][7:0]};  // high byte first
        return inv ? ~p : p;
    endfunction

    function automatic logic [23:0] expand(input logic [15:0] pix);
        return {pix[15:11], 3'b000, pix[10:5], 2'b00, pix[4:0], 3'b000};
    endfunction

    task automatic check(input string name, input logic [23:0] got, input logic [23:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            $display("tests failed");
            $fatal(1, "stopped at first failing check");
        end
    endtask

    task automatic pulse_vsync(input bit v1, input bit v2);
        @(posedge clk);
        cam1_vsync <= v1;
        cam2_vsync <= v2;
        @(posedge clk);
        cam1_vsync <= 1'b0;
        cam2_vsync <= 1'b0;
    endtask

    task automatic stream(input bit en1, input bit en2, input bit inv1, input bit inv2,
                          input int nbytes);
        int i1;
        int i2;
        i1 = en1 ? 0 : nbytes;
        i2 = en2 ? 0 : nbytes;
        while (i1 < nbytes || i2 < nbytes) begin
            @(posedge clk);
            cam1_href <= 1'b0;
            cam2_href <= 1'b0;
            if (i1 < nbytes && href_slot()) begin
                cam1_href <= 1'b1;
                cam1_data <= stim[i1][7:0] ^ {8{inv1}};
                i1++;
            end
            if (i2 < nbytes && href_slot()) begin
                cam2_href <= 1'b1;
                cam2_data <= stim[64+i2][7:0] ^ {8{inv2}};
                i2++;
            end
        end
        @(posedge clk);
        cam1_href <= 1'b0;
        cam2_href <= 1'b0;
    endtask

    // both camera writers idle and empty for a few cycles in a row
    task automatic wait_writes_idle();
        int quiet;
        quiet = 0;
        while (quiet < 4) begin
            @(negedge clk);
            if (uut.m_req[0].aw.valid || uut.m_req[0].bready ||
                uut.m_req[1].aw.valid || uut.m_req[1].bready)
                quiet = 0;
            else
                quiet++;
        end
    endtask

    task automatic run_display(input bit second_start);
        seen.delete();
        @(posedge clk);
        disp_start <= 1'b1;
        @(posedge clk);
        disp_start <= 1'b0;
        do @(negedge clk); while (!disp_busy);
        if (second_start) begin
            while (seen.size() < 10)
                @(negedge clk);
            check("disp_busy", disp_busy, 1'b1);
            @(posedge clk);
            disp_start <= 1'b1;     // should be ignored mid frame
            @(posedge clk);
            disp_start <= 1'b0;
        end
        do @(negedge clk); while (disp_busy);
        repeat (3) @(negedge clk);
        check("disp_busy", disp_busy, 1'b0);
        check("hdmi_de_count", seen.size(), n_pixels);
    endtask

    task automatic check_frame(input int lo, input int hi, input bit inv);
        for (int k = lo; k < hi; k++)
            check($sformatf("hdmi_rgb[%0d]", k), seen[k], expand(cam_pixel(k, inv)));
    endtask

    // ******************************
    // test sequence
    // ******************************

    initial begin
        rst_n      = 1'b0;
        cam1_vsync = 1'b0;
        cam1_href  = 1'b0;
        cam1_data  = 8'h00;
        cam2_vsync = 1'b0;
        cam2_href  = 1'b0;
        cam2_data  = 8'h00;
        disp_start = 1'b0;
        $readmemh("verification/aimbot_stimulus.txt", stim);
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        check("hdmi_de", hdmi_de, 1'b0);
        check("disp_busy", disp_busy, 1'b0);
        check("overflow1", overflow1, 1'b0);
        check("overflow2", overflow2, 1'b0);
        for (int k = 0; k < n_pixels; k++)
            check($sformatf("stim_expected[%0d]", k), stim[128+k], expand(cam_pixel(k, 1'b0)));

        // camera 1 alone
        pulse_vsync(1'b1, 1'b0);
        stream(1'b1, 1'b0, 1'b0, 1'b0, 64);
        wait_writes_idle();
        run_display(1'b0);
        for (int k = 0; k < frame_pixels; k++)
            check($sformatf("hdmi_rgb[%0d]", k), seen[k], stim[128+k]);

        // both cameras at once, camera 1 with inverted bytes
        pulse_vsync(1'b1, 1'b1);
        stream(1'b1, 1'b1, 1'b1, 1'b0, 64);
        wait_writes_idle();
        check("overflow1", overflow1, 1'b0);
        check("overflow2", overflow2, 1'b0);
        run_display(1'b0);
        check_frame(0, frame_pixels, 1'b1);
        check_frame(frame_pixels, n_pixels, 1'b0);

        // vsync mid frame, odd byte count leaves half a pixel behind
        pulse_vsync(1'b1, 1'b0);
        stream(1'b1, 1'b0, 1'b1, 1'b0, 21);
        pulse_vsync(1'b1, 1'b0);
        stream(1'b1, 1'b0, 1'b0, 1'b0, 64);
        wait_writes_idle();
        run_display(1'b0);
        check_frame(0, n_pixels, 1'b0);

        // display pass racing both writers
        pulse_vsync(1'b1, 1'b1);
        fork
            stream(1'b1, 1'b1, 1'b1, 1'b1, 64);
            run_display(1'b0);
        join
        wait_writes_idle();
        for (int k = 0; k < n_pixels; k++) begin
            if (seen[k] !== expand(cam_pixel(k, 1'b1)))
                check($sformatf("hdmi_rgb[%0d]", k), seen[k], expand(cam_pixel(k, 1'b0)));
        end

        // second start while busy
        run_display(1'b1);
        check_frame(0, n_pixels, 1'b1);

        $display("all tests passed");
        $finish;
    end

endmodule : aimbot_tb

//--- verilog.f
rtl/aimbot_pkg.sv
rtl/ov5640_reader.sv
rtl/mem_arbiter.sv
rtl/frame_ram.sv
rtl/display_reader.sv
rtl/aimbot_top.sv
verification/aimbot_tb.sv
